// File: sequencer_consts.svh
// data width, opcode fields and values, trap vector numbers
`ifndef SEQUENCER_CONSTS_SVH
`define SEQUENCER_CONSTS_SVH

`define DATA_W          16

// instruction word field positions
`define OPC_BYTE_BIT    15
`define DOP_HI          14
`define DOP_LO          12
`define SOP_HI          15
`define SOP_LO          6
`define SRC_MODE_HI     11
`define SRC_MODE_LO     9
`define DST_MODE_HI     5
`define DST_MODE_LO     3

// whole-word opcodes
`define OPC_HALT        16'o000000
`define OPC_BPT         16'o000003
`define OPC_IOT         16'o000004
`define OPC_RESET       16'o000005
`define OPC_NOP         16'o000240

// single-operand, bits 15:6
`define OPC_CLR         10'o0050
`define OPC_COM         10'o0051
`define OPC_INC         10'o0052
`define OPC_DEC         10'o0053
`define OPC_NEG         10'o0054
`define OPC_TST         10'o0057

// double-operand, bits 14:12
`define OPC_MOV         3'o1
`define OPC_CMP         3'o2
`define OPC_BIT         3'o3
`define OPC_BIC         3'o4
`define OPC_BIS         3'o5
`define OPC_ADD         3'o6

// trap vectors
`define VEC_RSVD        16'o000004
`define VEC_BUSERR      16'o000004
`define VEC_HALT        16'o000004
`define VEC_BPT         16'o000014
`define VEC_IOT         16'o000020

`endif

// File: sequencer_pkg.sv
// sequencer types: states, instructions, alu ops, bus and datapath selects, trap causes
package sequencer_pkg;

    typedef enum logic [3:0] {
        S_FETCH,
        S_DECODE,
        S_SRC_OP,
        S_SRC_RD,
        S_DST_OP,
        S_DST_RD,
        S_EXEC,
        S_WB_REG,
        S_WB_MEM,
        S_TRAP,
        S_IRQ_RD,
        S_VEC_RD1,
        S_VEC_RD2,
        S_PUSH1,
        S_PUSH2
    } seq_state_e;

    typedef enum logic [4:0] {
        I_RSVD, I_HALT, I_BPT, I_IOT, I_RESET, I_NOP,
        I_CLR, I_COM, I_INC, I_DEC, I_NEG, I_TST,
        I_MOV, I_CMP, I_BIT, I_BIC, I_BIS, I_ADD
    } instr_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_CLR, ALU_COM, ALU_INC, ALU_DEC, ALU_NEG, ALU_TST,
        ALU_MOV, ALU_CMP, ALU_BIT, ALU_BIC, ALU_BIS, ALU_ADD
    } alu_op_e;

    // bus address source
    typedef enum logic [2:0] {
        ADR_PC, ADR_SRC, ADR_DST, ADR_ADR, ADR_SP, ADR_VEC
    } adr_src_e;

    // operand latch command
    typedef enum logic [2:0] {
        OPL_NONE, OPL_REG_SRC, OPL_REG_DST, OPL_BUS_SRC, OPL_BUS_DST
    } opnd_load_e;

    // bus write data
    typedef enum logic [1:0] {
        DBO_RESULT, DBO_PSW, DBO_PC
    } dbo_sel_e;

    typedef enum logic [2:0] {
        TC_NONE, TC_RSVD, TC_BUSERR, TC_BPT, TC_IOT, TC_IRQ
    } trap_cause_e;

endpackage

// File: instr_decoder.sv
// instruction register and classification of the fetched word
`timescale 1ns/1ps
`include "sequencer_consts.svh"

module instr_decoder import sequencer_pkg::*; (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                ir_load_i,
    input  logic [`DATA_W-1:0]  data_i,
    output instr_e              instr_o,
    output logic                src_mode_o,
    output logic                dst_mode_o
);

    logic [`DATA_W-1:0] ir;
    logic [2:0]         src_field;
    logic [2:0]         dst_field;
    logic               src_ok;
    logic               dst_ok;

    // cleared to HALT so a stray decode traps
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ir <= `OPC_HALT;
        end else if (ir_load_i) begin
            ir <= data_i;
        end
    end

    assign src_field = ir[`SRC_MODE_HI:`SRC_MODE_LO];
    assign dst_field = ir[`DST_MODE_HI:`DST_MODE_LO];

    // only modes 0 and 1 are kept
    assign src_ok = (src_field[2:1] == 2'b00);
    assign dst_ok = (dst_field[2:1] == 2'b00);

    assign src_mode_o = src_field[0];
    assign dst_mode_o = dst_field[0];

    always_comb begin
        instr_o = I_RSVD;
        if (ir == `OPC_HALT) begin
            instr_o = I_HALT;
        end else if (ir == `OPC_BPT) begin
            instr_o = I_BPT;
        end else if (ir == `OPC_IOT) begin
            instr_o = I_IOT;
        end else if (ir == `OPC_RESET) begin
            instr_o = I_RESET;
        end else if (ir == `OPC_NOP) begin
            instr_o = I_NOP;
        end else if (!ir[`OPC_BYTE_BIT] && ir[`DOP_HI:`DOP_LO] != 3'o0) begin
            // double operand, word form only
            if (src_ok && dst_ok) begin
                case (ir[`DOP_HI:`DOP_LO])
                    `OPC_MOV: instr_o = I_MOV;
                    `OPC_CMP: instr_o = I_CMP;
                    `OPC_BIT: instr_o = I_BIT;
                    `OPC_BIC: instr_o = I_BIC;
                    `OPC_BIS: instr_o = I_BIS;
                    `OPC_ADD: instr_o = I_ADD;
                    default:  instr_o = I_RSVD;
                endcase
            end
        end else if (dst_ok) begin
            case (ir[`SOP_HI:`SOP_LO])
                `OPC_CLR: instr_o = I_CLR;
                `OPC_COM: instr_o = I_COM;
                `OPC_INC: instr_o = I_INC;
                `OPC_DEC: instr_o = I_DEC;
                `OPC_NEG: instr_o = I_NEG;
                `OPC_TST: instr_o = I_TST;
                default:  instr_o = I_RSVD;
            endcase
        end
    end

endmodule

// File: exec_table.sv
// execute table: alu operation, condition-code update and write-back per instruction
`timescale 1ns/1ps

module exec_table import sequencer_pkg::*; (
    input  instr_e   instr_i,
    input  logic     dst_mode_i,
    output alu_op_e  alu_op_o,
    output logic     cc_update_o,
    output logic     writes_dst_o,
    output logic     wb_memory_o
);

    always_comb begin
        alu_op_o = ALU_NONE;
        case (instr_i)
            I_CLR:   alu_op_o = ALU_CLR;
            I_COM:   alu_op_o = ALU_COM;
            I_INC:   alu_op_o = ALU_INC;
            I_DEC:   alu_op_o = ALU_DEC;
            I_NEG:   alu_op_o = ALU_NEG;
            I_TST:   alu_op_o = ALU_TST;
            I_MOV:   alu_op_o = ALU_MOV;
            I_CMP:   alu_op_o = ALU_CMP;
            I_BIT:   alu_op_o = ALU_BIT;
            I_BIC:   alu_op_o = ALU_BIC;
            I_BIS:   alu_op_o = ALU_BIS;
            I_ADD:   alu_op_o = ALU_ADD;
            default: alu_op_o = ALU_NONE;
        endcase
    end

    // every alu instruction sets the flags
    assign cc_update_o = (alu_op_o != ALU_NONE);

    // compare-type ops only look at the result
    always_comb begin
        case (alu_op_o)
            ALU_NONE,
            ALU_TST,
            ALU_CMP,
            ALU_BIT: writes_dst_o = 1'b0;
            default: writes_dst_o = 1'b1;
        endcase
    end

    // deferred destination writes back through ADR
    assign wb_memory_o = writes_dst_o & dst_mode_i;

endmodule

// File: control_fsm.sv
// sequencer FSM: fetch, operand fetch, execute, write-back and trap sequence
`timescale 1ns/1ps

module control_fsm import sequencer_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         ready_i,
    input  logic         ierror_i,
    input  logic         irq_i,
    input  instr_e       instr_i,
    input  logic         src_mode_i,
    input  logic         dst_mode_i,
    input  alu_op_e      alu_op_i,
    input  logic         cc_update_i,
    input  logic         writes_dst_i,
    input  logic         wb_memory_i,
    output logic         ir_load_o,
    output logic         dati_o,
    output logic         dato_o,
    output logic         ifetch_o,
    output logic         iako_o,
    output logic         initq_o,
    output adr_src_e     bus_adr_sel_o,
    output opnd_load_e   opnd_load_o,
    output alu_op_e      alu_op_o,
    output logic         alu_cc_o,
    output logic         reg_write_o,
    output logic         pc_inc_o,
    output logic         sp_dec_o,
    output dbo_sel_e     dbo_sel_o,
    output trap_cause_e  trap_cause_o
);

    seq_state_e   state;
    seq_state_e   next_state;
    trap_cause_e  cause_r;
    trap_cause_e  cause_next;
    logic         bus_done;
    logic         irq_check;

    // error takes priority over ready
    assign bus_done = ready_i & ~ierror_i;

    // ========================================================================
    // state and trap cause registers
    // ========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= S_FETCH;
            cause_r <= TC_NONE;
        end else begin
            state   <= next_state;
            cause_r <= cause_next;
        end
    end

    // ========================================================================
    // next state and commands
    // ========================================================================
    always_comb begin
        next_state    = state;
        cause_next    = cause_r;
        irq_check     = 1'b0;
        ir_load_o     = 1'b0;
        dati_o        = 1'b0;
        dato_o        = 1'b0;
        ifetch_o      = 1'b0;
        iako_o        = 1'b0;
        initq_o       = 1'b0;
        bus_adr_sel_o = ADR_PC;
        opnd_load_o   = OPL_NONE;
        alu_op_o      = ALU_NONE;
        alu_cc_o      = 1'b0;
        reg_write_o   = 1'b0;
        pc_inc_o      = 1'b0;
        sp_dec_o      = 1'b0;
        dbo_sel_o     = DBO_RESULT;
        trap_cause_o  = TC_NONE;

        case (state)
            S_FETCH: begin
                dati_o   = 1'b1;
                ifetch_o = 1'b1;
                if (bus_done) begin
                    ir_load_o  = 1'b1;
                    pc_inc_o   = 1'b1;
                    next_state = S_DECODE;
                end
            end
            S_DECODE: begin
                case (instr_i)
                    I_RSVD, I_HALT: begin
                        cause_next = TC_RSVD;
                        next_state = S_TRAP;
                    end
                    I_BPT: begin
                        cause_next = TC_BPT;
                        next_state = S_TRAP;
                    end
                    I_IOT: begin
                        cause_next = TC_IOT;
                        next_state = S_TRAP;
                    end
                    I_RESET: begin
                        initq_o   = 1'b1;
                        irq_check = 1'b1;
                    end
                    I_NOP:   irq_check  = 1'b1;
                    I_CLR, I_COM, I_INC, I_DEC, I_NEG, I_TST: next_state = S_DST_OP;
                    default: next_state = S_SRC_OP;
                endcase
            end
            S_SRC_OP: begin
                opnd_load_o = OPL_REG_SRC;
                next_state  = src_mode_i ? S_SRC_RD : S_DST_OP;
            end
            S_SRC_RD: begin
                dati_o        = 1'b1;
                bus_adr_sel_o = ADR_SRC;
                if (bus_done) begin
                    opnd_load_o = OPL_BUS_SRC;
                    next_state  = S_DST_OP;
                end
            end
            S_DST_OP: begin
                opnd_load_o = OPL_REG_DST;
                next_state  = dst_mode_i ? S_DST_RD : S_EXEC;
            end
            S_DST_RD: begin
                dati_o        = 1'b1;
                bus_adr_sel_o = ADR_DST;
                if (bus_done) begin
                    opnd_load_o = OPL_BUS_DST;
                    next_state  = S_EXEC;
                end
            end
            S_EXEC: begin
                alu_op_o = alu_op_i;
                alu_cc_o = cc_update_i;
                if (!writes_dst_i) begin
                    irq_check = 1'b1;
                end else begin
                    next_state = wb_memory_i ? S_WB_MEM : S_WB_REG;
                end
            end
            S_WB_REG: begin
                reg_write_o = 1'b1;
                irq_check   = 1'b1;
            end
            S_WB_MEM: begin
                dato_o        = 1'b1;
                bus_adr_sel_o = ADR_ADR;
                irq_check     = bus_done;
            end
            S_TRAP: begin
                trap_cause_o = cause_r;
                next_state   = (cause_r == TC_IRQ) ? S_IRQ_RD : S_VEC_RD1;
            end
            S_IRQ_RD: begin
                // device supplies the vector
                trap_cause_o  = cause_r;
                dati_o        = 1'b1;
                iako_o        = 1'b1;
                bus_adr_sel_o = ADR_VEC;
                if (bus_done) next_state = S_VEC_RD1;
            end
            S_VEC_RD1: begin
                trap_cause_o  = cause_r;
                dati_o        = 1'b1;
                bus_adr_sel_o = ADR_VEC;
                if (bus_done) next_state = S_VEC_RD2;
            end
            S_VEC_RD2: begin
                trap_cause_o  = cause_r;
                dati_o        = 1'b1;
                bus_adr_sel_o = ADR_VEC;
                if (bus_done) begin
                    sp_dec_o   = 1'b1;
                    next_state = S_PUSH1;
                end
            end
            S_PUSH1: begin
                trap_cause_o  = cause_r;
                dato_o        = 1'b1;
                bus_adr_sel_o = ADR_SP;
                dbo_sel_o     = DBO_PSW;
                if (bus_done) begin
                    sp_dec_o   = 1'b1;
                    next_state = S_PUSH2;
                end
            end
            S_PUSH2: begin
                trap_cause_o  = cause_r;
                dato_o        = 1'b1;
                bus_adr_sel_o = ADR_SP;
                dbo_sel_o     = DBO_PC;
                if (bus_done) next_state = S_FETCH;
            end
            default: next_state = S_FETCH;
        endcase

        // interrupt check between instructions
        if (irq_check) begin
            if (irq_i) begin
                cause_next = TC_IRQ;
                next_state = S_TRAP;
            end else begin
                next_state = S_FETCH;
            end
        end

        // any bus cycle may end in a bus error
        if ((dati_o || dato_o) && ierror_i) begin
            cause_next = TC_BUSERR;
            next_state = S_TRAP;
        end
    end

endmodule

// File: control_top.sv
// top level: decoder, execute table and sequencer FSM
`timescale 1ns/1ps
`include "sequencer_consts.svh"

module control_top import sequencer_pkg::*; (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                ready_i,
    input  logic                ierror_i,
    input  logic                irq_i,
    input  logic [`DATA_W-1:0]  data_i,
    output logic                dati_o,
    output logic                dato_o,
    output logic                ifetch_o,
    output logic                iako_o,
    output logic                initq_o,
    output adr_src_e            bus_adr_sel_o,
    output opnd_load_e          opnd_load_o,
    output alu_op_e             alu_op_o,
    output logic                alu_cc_o,
    output logic                reg_write_o,
    output logic                pc_inc_o,
    output logic                sp_dec_o,
    output dbo_sel_e            dbo_sel_o,
    output trap_cause_e         trap_cause_o
);

    logic     ir_load;
    instr_e   instr;
    logic     src_mode;
    logic     dst_mode;
    alu_op_e  alu_op;
    logic     cc_update;
    logic     writes_dst;
    logic     wb_memory;

    instr_decoder decoder_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .ir_load_i  (ir_load),
        .data_i     (data_i),
        .instr_o    (instr),
        .src_mode_o (src_mode),
        .dst_mode_o (dst_mode)
    );

    exec_table table_i (
        .instr_i      (instr),
        .dst_mode_i   (dst_mode),
        .alu_op_o     (alu_op),
        .cc_update_o  (cc_update),
        .writes_dst_o (writes_dst),
        .wb_memory_o  (wb_memory)
    );

    control_fsm fsm_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .ready_i       (ready_i),
        .ierror_i      (ierror_i),
        .irq_i         (irq_i),
        .instr_i       (instr),
        .src_mode_i    (src_mode),
        .dst_mode_i    (dst_mode),
        .alu_op_i      (alu_op),
        .cc_update_i   (cc_update),
        .writes_dst_i  (writes_dst),
        .wb_memory_i   (wb_memory),
        .ir_load_o     (ir_load),
        .dati_o        (dati_o),
        .dato_o        (dato_o),
        .ifetch_o      (ifetch_o),
        .iako_o        (iako_o),
        .initq_o       (initq_o),
        .bus_adr_sel_o (bus_adr_sel_o),
        .opnd_load_o   (opnd_load_o),
        .alu_op_o      (alu_op_o),
        .alu_cc_o      (alu_cc_o),
        .reg_write_o   (reg_write_o),
        .pc_inc_o      (pc_inc_o),
        .sp_dec_o      (sp_dec_o),
        .dbo_sel_o     (dbo_sel_o),
        .trap_cause_o  (trap_cause_o)
    );

endmodule

// File: tb_control_top.sv
// testbench for control_top: clock, reset, LFSR, bus responder, program and checks
`timescale 1ns/1ps
`include "sequencer_consts.svh"

module tb_control_top import sequencer_pkg::*; ();

    localparam int MAX_PROG  = 32;
    localparam int RUN_LIMIT = 4000;

    logic               clk;
    logic               reset_n;
    logic               ready_i;
    logic               ierror_i;
    logic               irq_i;
    logic [`DATA_W-1:0] data_i;
    logic               dati_o;
    logic               dato_o;
    logic               ifetch_o;
    logic               iako_o;
    logic               initq_o;
    adr_src_e           bus_adr_sel_o;
    opnd_load_e         opnd_load_o;
    alu_op_e            alu_op_o;
    logic               alu_cc_o;
    logic               reg_write_o;
    logic               pc_inc_o;
    logic               sp_dec_o;
    dbo_sel_e           dbo_sel_o;
    trap_cause_e        trap_cause_o;

    // program and expected results per instruction
    logic [`DATA_W-1:0] p_word [MAX_PROG];
    alu_op_e            p_alu [MAX_PROG];
    int                 p_regwr [MAX_PROG];
    int                 p_oprd [MAX_PROG];
    int                 p_memwr [MAX_PROG];
    trap_cause_e        p_cause [MAX_PROG];
    int                 p_initq [MAX_PROG];
    logic               p_err [MAX_PROG];
    logic               p_irq [MAX_PROG];
    int                 n_prog;

    logic [16:0] lfsr;
    logic        done;

    control_top dut_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .ready_i       (ready_i),
        .ierror_i      (ierror_i),
        .irq_i         (irq_i),
        .data_i        (data_i),
        .dati_o        (dati_o),
        .dato_o        (dato_o),
        .ifetch_o      (ifetch_o),
        .iako_o        (iako_o),
        .initq_o       (initq_o),
        .bus_adr_sel_o (bus_adr_sel_o),
        .opnd_load_o   (opnd_load_o),
        .alu_op_o      (alu_op_o),
        .alu_cc_o      (alu_cc_o),
        .reg_write_o   (reg_write_o),
        .pc_inc_o      (pc_inc_o),
        .sp_dec_o      (sp_dec_o),
        .dbo_sel_o     (dbo_sel_o),
        .trap_cause_o  (trap_cause_o)
    );

    always #20 clk = ~clk;

    // x^17 + x^14 + 1, one step per bit
    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    task automatic report_value(input string name, input int got, input int exp);
        $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_text(input string what);
        $display("error at t=%0t: %s", $time, what);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else report_value(name, got, exp);
    endtask

    task automatic add_instr(input logic [15:0] w, input alu_op_e a, input int rw,
                             input int rd, input int mw, input trap_cause_e c,
                             input int iq, input logic e, input logic q);
        p_word[n_prog]  = w;
        p_alu[n_prog]   = a;
        p_regwr[n_prog] = rw;
        p_oprd[n_prog]  = rd;
        p_memwr[n_prog] = mw;
        p_cause[n_prog] = c;
        p_initq[n_prog] = iq;
        p_err[n_prog]   = e;
        p_irq[n_prog]   = q;
        n_prog++;
    endtask

    // ========================================================================
    // bus responder
    // ========================================================================
    int   fidx;
    int   cur_idx;
    int   wait_cnt;
    logic busy;

    always @(posedge clk) begin
        if (!reset_n) begin
            busy <= 1'b0;
        end else if (ready_i || ierror_i) begin
            ready_i  <= 1'b0;
            ierror_i <= 1'b0;
            busy     <= 1'b0;
            if (iako_o && ready_i) begin
                irq_i <= 1'b0;
            end
        end else if (dati_o || dato_o) begin
            if (!busy) begin
                wait_cnt = {next_random_bit(), next_random_bit()};
                busy <= 1'b1;
            end
            if (wait_cnt == 0) begin
                if (ifetch_o) begin
                    data_i  <= (fidx < n_prog) ? p_word[fidx] : `OPC_NOP;
                    cur_idx = fidx;
                    if (fidx < n_prog && p_irq[fidx]) begin
                        irq_i <= 1'b1;
                    end
                    fidx++;
                    ready_i <= 1'b1;
                end else if (dati_o && trap_cause_o == TC_NONE && cur_idx < n_prog
                             && p_err[cur_idx]) begin
                    ierror_i <= 1'b1;
                end else begin
                    data_i  <= 16'h5a00 ^ fidx[15:0];
                    ready_i <= 1'b1;
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    // ========================================================================
    // monitor and checks
    // ========================================================================
    int          mon_idx;
    int          rd_cnt;
    int          wr_cnt;
    int          regwr_cnt;
    int          initq_cnt;
    int          spdec_cnt;
    int          exec_cnt;
    int          cmd_cnt;
    int          push_cnt;
    int          src_ld_cnt;
    int          dst_ld_cnt;
    int          bus_ld_cnt;
    logic        dst_seen;
    logic        iako_done;
    trap_cause_e seen_cause;
    logic        prev_open;
    logic        prev_rd;
    logic        prev_wr;
    adr_src_e    prev_adr;

    task automatic check_summary(input int i);
        int   ex_rd;
        int   ex_wr;
        logic two_op;
        ex_rd = p_oprd[i];
        ex_wr = p_memwr[i];
        two_op = p_alu[i] inside {ALU_MOV, ALU_CMP, ALU_BIT, ALU_BIC, ALU_BIS, ALU_ADD};
        if (p_cause[i] != TC_NONE) begin
            ex_rd += (p_cause[i] == TC_IRQ) ? 3 : 2;
            ex_wr += 2;
        end
        check_value("operand_and_vector_reads", rd_cnt, ex_rd);
        check_value("bus_writes", wr_cnt, ex_wr);
        check_value("reg_write_o", regwr_cnt, p_regwr[i]);
        check_value("initq_o", initq_cnt, p_initq[i]);
        check_value("sp_dec_o", spdec_cnt, (p_cause[i] != TC_NONE) ? 2 : 0);
        check_value("execute_cycles", exec_cnt, (p_alu[i] != ALU_NONE) ? 1 : 0);
        check_value("trap_cause_o", seen_cause, p_cause[i]);
        if (p_alu[i] == ALU_NONE && !p_err[i]) begin
            check_value("datapath_commands", cmd_cnt, 0);
        end
        if (!p_err[i]) begin
            check_value("opnd_load_o reg_src", src_ld_cnt, two_op ? 1 : 0);
            check_value("opnd_load_o reg_dst", dst_ld_cnt, (p_alu[i] != ALU_NONE) ? 1 : 0);
            check_value("opnd_load_o bus", bus_ld_cnt, p_oprd[i]);
        end
    endtask

    task automatic clear_counts();
        rd_cnt     = 0;
        wr_cnt     = 0;
        regwr_cnt  = 0;
        initq_cnt  = 0;
        spdec_cnt  = 0;
        exec_cnt   = 0;
        cmd_cnt    = 0;
        push_cnt   = 0;
        src_ld_cnt = 0;
        dst_ld_cnt = 0;
        bus_ld_cnt = 0;
        dst_seen   = 1'b0;
        iako_done  = 1'b0;
        seen_cause = TC_NONE;
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            assert (dati_o && ifetch_o && !dato_o && !iako_o && !initq_o && !reg_write_o
                    && !pc_inc_o && !sp_dec_o)
                else report_text("outputs not at their reset values");
            prev_open = 1'b0;
        end else begin
            // fetch and bus rules
            if (ifetch_o) begin
                check_value("dati_o", dati_o, 1);
                check_value("bus_adr_sel_o", bus_adr_sel_o, ADR_PC);
            end
            check_value("pc_inc_o", pc_inc_o, ifetch_o && ready_i && !ierror_i);
            assert (!(dati_o && dato_o)) else report_text("read and write at once");
            if (prev_open) begin
                check_value("dati_o", dati_o, prev_rd);
                check_value("dato_o", dato_o, prev_wr);
                check_value("bus_adr_sel_o", bus_adr_sel_o, prev_adr);
            end
            if (iako_o) begin
                check_value("trap_cause_o", trap_cause_o, TC_IRQ);
                check_value("dati_o", dati_o, 1);
            end
            if (dato_o && trap_cause_o != TC_NONE) begin
                check_value("bus_adr_sel_o", bus_adr_sel_o, ADR_SP);
                check_value("dbo_sel_o", dbo_sel_o, (push_cnt == 0) ? DBO_PSW : DBO_PC);
            end else if (dato_o) begin
                check_value("bus_adr_sel_o", bus_adr_sel_o, ADR_ADR);
                check_value("dbo_sel_o", dbo_sel_o, DBO_RESULT);
            end
            if (dati_o && !ifetch_o && trap_cause_o != TC_NONE) begin
                check_value("bus_adr_sel_o", bus_adr_sel_o, ADR_VEC);
                if (trap_cause_o == TC_IRQ && !iako_o) begin
                    assert (iako_done) else report_text("vector read before IRQ acknowledge");
                end
            end else if (dati_o && !ifetch_o) begin
                assert (bus_adr_sel_o == ADR_DST || (bus_adr_sel_o == ADR_SRC && !dst_seen))
                    else report_text("operand read at wrong address or out of order");
                if (bus_adr_sel_o == ADR_DST) begin
                    dst_seen = 1'b1;
                end
                // operand latched from the bus in the completion cycle
                if (ready_i && !ierror_i) begin
                    check_value("opnd_load_o", opnd_load_o,
                                (bus_adr_sel_o == ADR_SRC) ? OPL_BUS_SRC : OPL_BUS_DST);
                end
            end
            if (alu_op_o != ALU_NONE) begin
                check_value("alu_op_o", alu_op_o, p_alu[mon_idx]);
                check_value("alu_cc_o", alu_cc_o, 1);
            end

            // per-instruction counts
            if (ifetch_o && ready_i && !ierror_i) begin
                if (mon_idx >= 0) begin
                    check_summary(mon_idx);
                end
                clear_counts();
                mon_idx++;
                if (mon_idx >= n_prog) begin
                    done = 1'b1;
                end
            end else if (mon_idx >= 0) begin
                if (dati_o && ready_i && !ierror_i) begin
                    rd_cnt++;
                    if (iako_o) begin
                        iako_done = 1'b1;
                    end
                end
                if (dato_o && ready_i && !ierror_i) begin
                    wr_cnt++;
                    if (trap_cause_o != TC_NONE) begin
                        push_cnt++;
                    end
                end
                regwr_cnt += reg_write_o;
                initq_cnt += initq_o;
                spdec_cnt += sp_dec_o;
                exec_cnt  += (alu_op_o != ALU_NONE);
                cmd_cnt   += (opnd_load_o != OPL_NONE) || reg_write_o || (alu_op_o != ALU_NONE);
                src_ld_cnt += (opnd_load_o == OPL_REG_SRC);
                dst_ld_cnt += (opnd_load_o == OPL_REG_DST);
                bus_ld_cnt += (opnd_load_o == OPL_BUS_SRC) || (opnd_load_o == OPL_BUS_DST);
                if (trap_cause_o != TC_NONE) begin
                    seen_cause = trap_cause_o;
                end
            end
            prev_open = (dati_o || dato_o) && !ready_i && !ierror_i;
            prev_rd   = dati_o;
            prev_wr   = dato_o;
            prev_adr  = bus_adr_sel_o;
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        int cycles;
        clk      = 1'b0;
        reset_n  = 1'b0;
        ready_i  = 1'b0;
        ierror_i = 1'b0;
        irq_i    = 1'b0;
        data_i   = '0;
        lfsr     = 17'd99325;
        done     = 1'b0;
        fidx     = 0;
        cur_idx  = 0;
        wait_cnt = 0;
        mon_idx  = -1;
        n_prog   = 0;
        clear_counts();

        // register mode alu instructions
        add_instr(16'o010102, ALU_MOV, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o005003, ALU_CLR, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o005103, ALU_COM, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o005203, ALU_INC, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o005303, ALU_DEC, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o005403, ALU_NEG, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o005703, ALU_TST, 0, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o020102, ALU_CMP, 0, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o030102, ALU_BIT, 0, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o040102, ALU_BIC, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o050102, ALU_BIS, 1, 0, 0, TC_NONE, 0, 0, 0);
        add_instr(16'o060102, ALU_ADD, 1, 0, 0, TC_NONE, 0, 0, 0);
        // deferred operands
        add_instr(16'o005013, ALU_CLR, 0, 1, 1, TC_NONE, 0, 0, 0);
        add_instr(16'o061112, ALU_ADD, 0, 2, 1, TC_NONE, 0, 0, 0);
        add_instr(16'o005712, ALU_TST, 0, 1, 0, TC_NONE, 0, 0, 0);
        // traps
        add_instr(16'o016202, ALU_NONE, 0, 0, 0, TC_RSVD, 0, 0, 0);
        add_instr(16'o105003, ALU_NONE, 0, 0, 0, TC_RSVD, 0, 0, 0);
        add_instr(`OPC_HALT, ALU_NONE, 0, 0, 0, TC_RSVD, 0, 0, 0);
        add_instr(`OPC_BPT, ALU_NONE, 0, 0, 0, TC_BPT, 0, 0, 0);
        add_instr(`OPC_IOT, ALU_NONE, 0, 0, 0, TC_IOT, 0, 0, 0);
        add_instr(16'o005213, ALU_NONE, 0, 0, 0, TC_BUSERR, 0, 1, 0);
        add_instr(`OPC_NOP, ALU_NONE, 0, 0, 0, TC_IRQ, 0, 0, 1);
        // reset and no-op
        add_instr(`OPC_RESET, ALU_NONE, 0, 0, 0, TC_NONE, 1, 0, 0);
        add_instr(`OPC_NOP, ALU_NONE, 0, 0, 0, TC_NONE, 0, 0, 0);

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        cycles = 0;
        while (!done && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout: program did not complete within %0d cycles", RUN_LIMIT);
            $display("Finished with errors");
            $fatal(1);
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

// File: project.f
+incdir+.
sequencer_pkg.sv
instr_decoder.sv
exec_table.sv
control_fsm.sv
control_top.sv
tb_control_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_control_top
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)
